//--- files.f
design/ramio_pkg.sv
design/cache_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/cache.sv
design/ramio.sv
design/ramio_top.sv
test/burst_ram_model.sv
test/ramio_tb.sv

//--- Makefile
# Verilator build and run for the ramio subsystem testbench

VERILATOR ?= verilator
TOP       := ramio_tb
FILELIST  := files.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
BUILD_DIR := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- test/ramio_tb.sv
/* ramio testbench
   RAM, LED and UART accesses through ramio_top, checked against a shadow memory */
`timescale 1ns/1ps
`default_nettype none

module ramio_tb;
  import ramio_pkg::*;

  localparam int          RAM_DEPTH_W   = 10;
  localparam int          CLK_FREQ      = 250_000_000;
  localparam int          BAUD_RATE     = 25_000_000;
  localparam int          BIT_CLKS      = CLK_FREQ / BAUD_RATE;
  localparam int          TIMEOUT       = 200;           // cycles per wait
  localparam logic [31:0] ADDR_LED      = 32'hFFFF_FFFF;
  localparam logic [31:0] ADDR_UART_OUT = 32'hFFFF_FFFE;
  localparam logic [31:0] ADDR_UART_IN  = 32'hFFFF_FFFD;
  // read codes are {sign, size}
  localparam logic [2:0]  RD_NONE = 3'b000;
  localparam logic [2:0]  RD_LB   = 3'b101;
  localparam logic [2:0]  RD_LBU  = 3'b001;
  localparam logic [2:0]  RD_LH   = 3'b110;
  localparam logic [2:0]  RD_LHU  = 3'b010;
  localparam logic [2:0]  RD_LW   = 3'b111;
  localparam logic [1:0]  WR_B    = 2'b01;
  localparam logic [1:0]  WR_H    = 2'b10;
  localparam logic [1:0]  WR_W    = 2'b11;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [1:0]  write_type;
  logic [2:0]  read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic        uart_rx;
  wire  [31:0] data_out;
  wire         data_out_ready;
  wire         busy;
  wire  [3:0]  led;
  wire         uart_tx;
  wire         br_cmd;
  wire         br_cmd_en;
  wire         br_rd_data_valid;
  wire  [RAM_DEPTH_W-1:0] br_addr;
  wire  [BR_DATA_W-1:0]   br_wr_data;
  wire  [BR_DATA_W-1:0]   br_rd_data;
  wire  [BR_MASK_W-1:0]   br_data_mask;

  logic [7:0]  shadow [0:8191];  // expected RAM bytes over 2^10 words of 8 bytes
  string       chk_name_q[$];
  logic [31:0] chk_addr_q[$];
  logic [31:0] chk_got_q[$];
  logic [31:0] chk_exp_q[$];
  int          mismatches = 0;
  int          failures   = 0;   // timeouts and framing problems

  ramio_top #(
    .ADDR_W(32), .RAM_DEPTH_W(RAM_DEPTH_W), .LINE_IX_W(4),
    .CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)
  ) UUT (
    .clk, .rst_n, .enable, .write_type, .read_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx, .uart_rx,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  burst_ram_model #(.ADDR_W(RAM_DEPTH_W), .DATA_W(BR_DATA_W), .LATENCY(3)) u_ram (
    .clk, .cmd(br_cmd), .cmd_en(br_cmd_en), .addr(br_addr), .wr_data(br_wr_data),
    .data_mask(br_data_mask), .rd_data(br_rd_data), .rd_data_valid(br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] extend(input logic [15:0] v, input logic half,
                                         input logic sign);
    if (half) return {{16{sign & v[15]}}, v};
    return {{24{sign & v[7]}}, v[7:0]};
  endfunction

  // expected read value from little endian lanes where an odd half address reads zero
  function automatic logic [31:0] ref_read(input logic [31:0] addr, input logic [2:0] rt);
    logic [12:0] a;
    logic [12:0] w;
    a = addr[12:0];
    w = {addr[12:2], 2'b00};
    case (rt[1:0])
      2'b01: return extend({8'h00, shadow[a]}, 1'b0, rt[2]);
      2'b10: begin
        if (addr[0]) return 32'h0;
        return extend({shadow[a + 13'd1], shadow[a]}, 1'b1, rt[2]);
      end
      2'b11: return {shadow[w + 13'd3], shadow[w + 13'd2], shadow[w + 13'd1], shadow[w]};
      default: return 32'h0;  // no size, no data
    endcase
  endfunction

  task automatic update_shadow(input logic [31:0] addr, input logic [1:0] wt,
                               input logic [31:0] d);
    case (wt)
      WR_B: shadow[addr[12:0]] = d[7:0];
      WR_H: begin
        if (!addr[0]) begin  // odd half writes nothing
          shadow[addr[12:0]]         = d[7:0];
          shadow[addr[12:0] + 13'd1] = d[15:8];
        end
      end
      WR_W: begin
        for (int i = 0; i < 4; i++) shadow[{addr[12:2], 2'b00} + 13'(i)] = d[8*i +: 8];
      end
      default: ;
    endcase
  endtask

  // one core access with inputs held until done and the read data returned
  task automatic access(input logic [31:0] addr, input logic [1:0] wt, input logic [2:0] rt,
                        input logic [31:0] d, output logic [31:0] q);
    int n;
    address    = addr;
    write_type = wt;
    read_type  = rt;
    data_in    = d;
    enable     = 1'b1;
    n = 0;
    #1;  // outputs settle after the falling edge
    while (busy || !data_out_ready) begin
      if (n == TIMEOUT) begin
        $display("ERROR: access to %h did not complete within %0d cycles", addr, TIMEOUT);
        failures++;
        break;
      end
      @(negedge clk);
      #1;
      n++;
    end
    q = data_out;
    @(negedge clk);  // rising edge in between commits it
    enable     = 1'b0;
    write_type = 2'b00;
    read_type  = RD_NONE;
  endtask

  task automatic queue_check(input string name, input logic [31:0] addr,
                             input logic [31:0] got, input logic [31:0] exp);
    chk_name_q.push_back(name);
    chk_addr_q.push_back(addr);
    chk_got_q.push_back(got);
    chk_exp_q.push_back(exp);
  endtask

  task automatic write_mem(input logic [31:0] addr, input logic [1:0] wt, input logic [31:0] d);
    logic [31:0] q;
    access(addr, wt, RD_NONE, d, q);
    update_shadow(addr, wt, d);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [2:0] rt,
                             input logic [31:0] exp);
    logic [31:0] q;
    access(addr, 2'b00, rt, 32'h0, q);
    queue_check("data_out", addr, q, exp);
  endtask

  task automatic read_lanes(input logic [31:0] a);
    for (int off = 0; off < 4; off++) begin
      read_expect(a + 32'(off), RD_LB, ref_read(a + 32'(off), RD_LB));
      read_expect(a + 32'(off), RD_LBU, ref_read(a + 32'(off), RD_LBU));
      read_expect(a + 32'(off), RD_LH, ref_read(a + 32'(off), RD_LH));
      read_expect(a + 32'(off), RD_LHU, ref_read(a + 32'(off), RD_LHU));
    end
    read_expect(a, RD_LW, ref_read(a, RD_LW));
  endtask

  // one frame from uart_tx with each bit sampled at its middle
  task automatic uart_capture(output logic [7:0] b);
    int n;
    b = 8'h00;
    n = 0;
    while (uart_tx !== 1'b0) begin
      if (n == TIMEOUT) begin
        $display("ERROR: no start bit seen on uart_tx");
        failures++;
        return;
      end
      @(negedge clk);
      n++;
    end
    repeat (BIT_CLKS / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = uart_tx;  // lsb first
    end
    repeat (BIT_CLKS) @(negedge clk);
    assert (uart_tx === 1'b1) else begin
      $display("ERROR: stop bit on uart_tx is low");
      failures++;
    end
  endtask

  task automatic uart_send(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
  endtask

  // read the UART in address until the received byte shows up
  task automatic uart_poll(input logic [2:0] rt, output logic [31:0] q);
    int n;
    q = 32'h0;
    n = 0;
    while (q == 32'h0) begin
      if (n == TIMEOUT) begin
        $display("ERROR: no byte arrived at the UART in address");
        failures++;
        return;
      end
      access(ADDR_UART_IN, 2'b00, rt, 32'h0, q);
      n++;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] addr,
                               input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s at %h: got %h, expected %h", name, addr, got, exp);
      mismatches++;
    end
  endtask

  always @(posedge clk) begin
    while (chk_got_q.size() > 0) begin
      compare_value(chk_name_q.pop_front(), chk_addr_q.pop_front(),
                    chk_got_q.pop_front(), chk_exp_q.pop_front());
    end
  end

  initial begin
    logic [31:0] addrs [16];
    logic [31:0] a;
    logic [31:0] b_addr;
    logic [31:0] d;
    logic [31:0] q;
    logic [7:0]  rx_b;
    int unsigned seed;
    seed       = $urandom(30);  // seeds the generator
    rst_n      = 1'b0;
    enable     = 1'b0;
    write_type = 2'b00;
    read_type  = RD_NONE;
    address    = 32'h0;
    data_in    = 32'h0;
    uart_rx    = 1'b1;          // line idle
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    queue_check("led", ADDR_LED, {28'h0, led}, 32'h0000_000F);

    // word writes then word reads where colliding indexes evict on the way
    for (int i = 0; i < 16; i++) begin
      addrs[i] = 32'($urandom_range(0, 2047)) << 2;
      write_mem(addrs[i], WR_W, $urandom);
    end
    for (int i = 0; i < 16; i++) read_expect(addrs[i], RD_LW, ref_read(addrs[i], RD_LW));

    // byte and half merges where misaligned halves change nothing
    for (int k = 0; k < 4; k++) begin
      a = 32'($urandom_range(0, 2047)) << 2;
      d = (k == 0) ? 32'h80F1_7F82 : $urandom;
      write_mem(a, WR_W, d);
      read_lanes(a);
      write_mem(a + 32'd2, WR_H, $urandom);
      write_mem(a + 32'd3, WR_H, $urandom);
      write_mem(a + 32'(k), WR_B, $urandom);  // each lane once over the loop
      read_lanes(a);
      write_mem(a + 32'd3, WR_B, $urandom);
      write_mem(a, WR_H, $urandom);
      write_mem(a + 32'd1, WR_H, $urandom);
      read_lanes(a);
    end

    // dirty write-back and refill through a shared index with another tag
    for (int k = 0; k < 6; k++) begin
      a      = 32'($urandom_range(0, 31)) << 2;           // tag 0
      b_addr = a + (32'($urandom_range(1, 63)) << 7);     // same index and half
      write_mem(a, WR_W, $urandom);
      write_mem(b_addr, WR_W, $urandom);
      read_expect(a, RD_LW, ref_read(a, RD_LW));
      read_expect(b_addr, RD_LW, ref_read(b_addr, RD_LW));
    end

    access(ADDR_LED, WR_B, RD_NONE, 32'h0000_005A, q);
    queue_check("led", ADDR_LED, {28'h0, led}, 32'h0000_000A);
    access(ADDR_LED, WR_B, RD_NONE, 32'h0000_0003, q);
    queue_check("led", ADDR_LED, {28'h0, led}, 32'h0000_0003);

    // transmit one fixed and one random byte
    for (int k = 0; k < 2; k++) begin
      d = (k == 0) ? 32'h0000_00A5 : {24'h0, 8'($urandom)};
      access(ADDR_UART_OUT, WR_B, RD_NONE, d, q);
      uart_capture(rx_b);
      queue_check("uart_tx", ADDR_UART_OUT, {24'h0, rx_b}, d);
    end

    // receive with lb then lbu on a repeated frame where each read consumes the byte
    uart_send(8'hC3);
    uart_poll(RD_LB, q);
    queue_check("data_out", ADDR_UART_IN, q, extend(16'h00C3, 1'b0, 1'b1));
    read_expect(ADDR_UART_IN, RD_LB, 32'h0);
    uart_send(8'hC3);
    uart_poll(RD_LBU, q);
    queue_check("data_out", ADDR_UART_IN, q, extend(16'h00C3, 1'b0, 1'b0));
    read_expect(ADDR_UART_IN, RD_LBU, 32'h0);

    repeat (2) @(negedge clk);  // checker drains its queue
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/burst_ram_model.sv
/* burst RAM model
   64-bit word memory, single-beat commands, fixed read latency */
`timescale 1ns/1ps
`default_nettype none

module burst_ram_model #(
  parameter int ADDR_W  = 10,
  parameter int DATA_W  = 64,
  parameter int LATENCY = 3
) (
  input  wire                clk,
  input  wire                cmd,         // 1: write, 0: read
  input  wire                cmd_en,
  input  wire [ADDR_W-1:0]   addr,
  input  wire [DATA_W-1:0]   wr_data,
  input  wire [DATA_W/8-1:0] data_mask,   // 1 keeps the stored byte
  output logic [DATA_W-1:0]  rd_data = '0,
  output logic               rd_data_valid = 1'b0
);
  logic [DATA_W-1:0] mem [2**ADDR_W];
  logic [ADDR_W-1:0] rd_addr;
  int                wait_cnt = 0;  // cycles left before the read beat

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem[i] = DATA_W'({32'(i) * 32'h9E37_79B1, ~32'(i) ^ 32'h5A5A_0F0F});  // all addr bits show
    end
  end

  always @(posedge clk) begin
    rd_data_valid <= 1'b0;
    if (cmd_en && cmd) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (!data_mask[b]) mem[addr][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
    if (cmd_en && !cmd) begin
      rd_addr  <= addr;
      wait_cnt <= LATENCY;
    end else if (wait_cnt > 0) begin
      wait_cnt <= wait_cnt - 1;
      if (wait_cnt == 1) begin  // last cycle of the latency
        rd_data       <= mem[rd_addr];
        rd_data_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/ramio_top.sv
/* ramio_top
   memory and I/O subsystem: mapper, cache and UART pair */
`timescale 1ns/1ps
`default_nettype none

module ramio_top #(
  parameter int ADDR_W      = 32,
  parameter int RAM_DEPTH_W = 10,
  parameter int LINE_IX_W   = 4,
  parameter int CLK_FREQ    = 20_250_000,
  parameter int BAUD_RATE   = 9600
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              enable,
  input  wire  [1:0]                       write_type,
  input  wire  [2:0]                       read_type,
  input  wire  [ADDR_W-1:0]                address,
  input  wire  [31:0]                      data_in,
  output logic [31:0]                      data_out,
  output logic                             data_out_ready,
  output logic                             busy,
  output logic [3:0]                       led,
  output logic                             uart_tx,
  input  wire                              uart_rx,
  output logic                             br_cmd,
  output logic                             br_cmd_en,
  output logic [RAM_DEPTH_W-1:0]           br_addr,
  output logic [ramio_pkg::BR_DATA_W-1:0]  br_wr_data,
  output logic [ramio_pkg::BR_MASK_W-1:0]  br_data_mask,
  input  wire  [ramio_pkg::BR_DATA_W-1:0]  br_rd_data,
  input  wire                              br_rd_data_valid
);
  import ramio_pkg::*;

  // I/O sits at the top of the address space
  localparam logic [ADDR_W-1:0] ADDR_LED      = '1;
  localparam logic [ADDR_W-1:0] ADDR_UART_OUT = ADDR_LED - ADDR_W'(1);
  localparam logic [ADDR_W-1:0] ADDR_UART_IN  = ADDR_LED - ADDR_W'(2);

  size_e     wr_type;
  read_req_u rd_req;
  logic [7:0] tx_data, rx_data;
  logic       tx_go, tx_bsy, rx_go, rx_dr;

  assign wr_type    = size_e'(write_type);
  assign rd_req.raw = read_type;

  cache_if #(.ADDR_W(ADDR_W)) mem_bus ();

  ramio #(
    .ADDR_W        (ADDR_W),
    .ADDR_LED      (ADDR_LED),
    .ADDR_UART_OUT (ADDR_UART_OUT),
    .ADDR_UART_IN  (ADDR_UART_IN)
  ) u_ramio (
    .clk, .rst_n, .enable,
    .write_type    (wr_type),
    .read_type     (rd_req),
    .address, .data_in, .data_out, .data_out_ready, .busy, .led,
    .uart_tx_data  (tx_data),
    .uart_tx_go    (tx_go),
    .uart_tx_bsy   (tx_bsy),
    .uart_rx_data  (rx_data),
    .uart_rx_dr    (rx_dr),
    .uart_rx_go    (rx_go),
    .mem           (mem_bus.requester)
  );

  cache #(
    .RAM_DEPTH_W (RAM_DEPTH_W),
    .LINE_IX_W   (LINE_IX_W)
  ) u_cache (
    .clk, .rst_n,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid,
    .mem (mem_bus.cache)
  );

  uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_tx (
    .clk, .rst_n, .data(tx_data), .go(tx_go), .tx(uart_tx), .bsy(tx_bsy)
  );

  uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_rx (
    .clk, .rst_n, .rx(uart_rx), .go(rx_go), .data(rx_data), .dr(rx_dr)
  );

endmodule

`default_nettype wire

//--- design/ramio.sv
/* ramio I/O mapper
   routes core accesses to the cache, the LED register or the UARTs,
   formats write lanes and extends read data */
`timescale 1ns/1ps
`default_nettype none

module ramio #(
  parameter int                ADDR_W        = 32,
  parameter logic [ADDR_W-1:0] ADDR_LED      = '1,
  parameter logic [ADDR_W-1:0] ADDR_UART_OUT = ADDR_LED - ADDR_W'(1),
  parameter logic [ADDR_W-1:0] ADDR_UART_IN  = ADDR_LED - ADDR_W'(2)
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        enable,
  input  wire ramio_pkg::size_e      write_type,
  input  wire ramio_pkg::read_req_u  read_type,
  input  wire [ADDR_W-1:0]           address,     // byte address
  input  wire [31:0]                 data_in,
  output logic [31:0]                data_out,
  output logic                       data_out_ready,
  output logic                       busy,
  output logic [3:0]                 led,
  output logic [7:0]                 uart_tx_data,
  output logic                       uart_tx_go,
  input  wire                        uart_tx_bsy,
  input  wire [7:0]                  uart_rx_data,
  input  wire                        uart_rx_dr,
  output logic                       uart_rx_go,
  cache_if.requester                 mem
);
  import ramio_pkg::*;

  logic        is_led, is_uart_out, is_uart_in, is_io;
  logic        rd_byte;    // byte sized read request
  logic        sign;
  logic [31:0] wr_lanes;   // write data replicated over the lanes
  logic [3:0]  wr_en;
  logic [7:0]  rd_lane8;
  logic [15:0] rd_lane16;
  logic [7:0]  io_byte;
  logic [7:0]  rx_byte;    // last received byte, cleared when read

  assign is_led      = address == ADDR_LED;
  assign is_uart_out = address == ADDR_UART_OUT;
  assign is_uart_in  = address == ADDR_UART_IN;
  assign is_io       = is_led || is_uart_out || is_uart_in;

  assign rd_byte = read_type.fields.size == SZ_BYTE;
  assign sign    = read_type.fields.sign;

  // I/O registers answer at once, RAM goes through the cache handshake
  assign busy           = is_io ? 1'b0 : mem.busy;
  assign data_out_ready = is_io ? 1'b1 : mem.data_out_ready;

  assign mem.enable       = enable && !is_io;
  assign mem.address      = {address[ADDR_W-1:2], 2'b00};  // cache sees words only
  assign mem.data_in      = wr_lanes;
  assign mem.write_enable = wr_en;

  always_comb begin
    wr_lanes = data_in;
    wr_en    = 4'b0000;
    case (write_type)
      SZ_BYTE: begin
        wr_lanes = {4{data_in[7:0]}};       // every lane, enable picks one
        wr_en    = 4'b0001 << address[1:0];
      end
      SZ_HALF: begin
        wr_lanes = {2{data_in[15:0]}};
        if (!address[0]) begin
          wr_en = address[1] ? 4'b1100 : 4'b0011;
        end
        // odd half address writes nothing
      end
      SZ_WORD: wr_en = 4'b1111;
      default: wr_en = 4'b0000;  // not a write
    endcase
  end

  assign rd_lane8  = mem.data_out[{address[1:0], 3'b000} +: 8];
  assign rd_lane16 = mem.data_out[{address[1], 4'b0000} +: 16];

  always_comb begin
    io_byte  = is_uart_in ? rx_byte : (is_uart_out ? uart_tx_data : {4'b0000, led});
    data_out = '0;
    if (read_type.raw != 3'b000) begin
      if (is_io) begin
        if (rd_byte) begin
          data_out = {{24{sign & io_byte[7]}}, io_byte};  // I/O is byte wide
        end
      end else begin
        case (read_type.fields.size)
          SZ_BYTE: data_out = {{24{sign & rd_lane8[7]}}, rd_lane8};
          SZ_HALF: begin
            if (!address[0]) begin
              data_out = {{16{sign & rd_lane16[15]}}, rd_lane16};
            end
          end
          SZ_WORD: data_out = mem.data_out;
          default: data_out = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led          <= 4'b1111;  // active low, all off
      uart_tx_data <= '0;
      uart_tx_go   <= 1'b0;
      rx_byte      <= '0;
      uart_rx_go   <= 1'b1;     // receiver armed from the start
    end else begin
      if (enable && is_uart_in && rd_byte) begin
        rx_byte <= '0;  // a read consumes the byte
      end else if (uart_rx_go && uart_rx_dr) begin
        rx_byte    <= uart_rx_data;
        uart_rx_go <= 1'b0;  // ack, dr clears
      end
      if (!uart_rx_go) uart_rx_go <= 1'b1;  // one cycle ack, then rearm
      if (uart_tx_go && !uart_tx_bsy) begin
        uart_tx_go   <= 1'b0;  // transmitter has taken the byte
        uart_tx_data <= '0;
      end
      if (enable && is_uart_out && write_type == SZ_BYTE) begin
        uart_tx_data <= data_in[7:0];
        uart_tx_go   <= 1'b1;
      end
      if (enable && is_led && write_type == SZ_BYTE) led <= data_in[3:0];
    end
  end

endmodule

`default_nettype wire

//--- design/cache.sv
/* cache
   direct-mapped write-back cache, 32-bit accesses over 64-bit burst RAM
   words, one RAM word per line */
`timescale 1ns/1ps
`default_nettype none

module cache #(
  parameter int RAM_DEPTH_W = 10,
  parameter int LINE_IX_W   = 4
) (
  input  wire                                clk,
  input  wire                                rst_n,
  output logic                               br_cmd,        // 1: write, 0: read
  output logic                               br_cmd_en,     // one-cycle pulse
  output logic [RAM_DEPTH_W-1:0]             br_addr,       // 64-bit word address
  output logic [ramio_pkg::BR_DATA_W-1:0]    br_wr_data,
  output logic [ramio_pkg::BR_MASK_W-1:0]    br_data_mask,
  input  wire  [ramio_pkg::BR_DATA_W-1:0]    br_rd_data,
  input  wire                                br_rd_data_valid,
  cache_if.cache                             mem
);
  import ramio_pkg::*;

  localparam int LINES = 2 ** LINE_IX_W;
  localparam int TAG_W = RAM_DEPTH_W - LINE_IX_W;

  localparam logic [1:0] S_IDLE      = 2'd0;
  localparam logic [1:0] S_WB        = 2'd1;  // write back dirty line
  localparam logic [1:0] S_FILL_REQ  = 2'd2;
  localparam logic [1:0] S_FILL_WAIT = 2'd3;

  logic [BR_DATA_W-1:0] data_mem [LINES];
  logic [TAG_W-1:0]     tag_mem  [LINES];
  logic [LINES-1:0]     valid;
  logic [LINES-1:0]     dirty;
  logic [1:0]           state;

  logic                 word_sel;  // low or high half of the line
  logic [LINE_IX_W-1:0] ix;
  logic [TAG_W-1:0]     tag;
  logic                 hit;

  assign word_sel = mem.address[2];
  assign ix       = mem.address[3 +: LINE_IX_W];
  assign tag      = mem.address[3 + LINE_IX_W +: TAG_W];
  assign hit      = mem.enable && valid[ix] && (tag_mem[ix] == tag);

  assign mem.busy           = state != S_IDLE;
  assign mem.data_out_ready = (state == S_IDLE) && hit;
  assign mem.data_out       = word_sel ? data_mem[ix][63:32] : data_mem[ix][31:0];
  assign br_data_mask       = '0;  // full word writes

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      valid     <= '0;
      dirty     <= '0;
      br_cmd    <= 1'b0;
      br_cmd_en <= 1'b0;
    end else begin
      br_cmd_en <= 1'b0;
      case (state)
        S_IDLE: begin
          if (hit && mem.write_enable != 4'b0000) begin
            dirty[ix] <= 1'b1;
          end else if (mem.enable && !hit) begin
            state <= dirty[ix] ? S_WB : S_FILL_REQ;  // dirty implies valid
          end
        end
        S_WB: begin
          br_cmd    <= 1'b1;
          br_cmd_en <= 1'b1;
          dirty[ix] <= 1'b0;
          state     <= S_FILL_REQ;
        end
        S_FILL_REQ: begin
          br_cmd    <= 1'b0;
          br_cmd_en <= 1'b1;
          state     <= S_FILL_WAIT;
        end
        default: begin  // S_FILL_WAIT
          if (br_rd_data_valid) begin
            valid[ix] <= 1'b1;
            state     <= S_IDLE;  // retried next cycle as a hit
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && hit) begin
      for (int i = 0; i < 4; i++) begin
        if (mem.write_enable[i]) begin
          data_mem[ix][{word_sel, i[1:0], 3'b000} +: 8] <= mem.data_in[8*i +: 8];
        end
      end
    end
    if (state == S_WB) begin
      br_addr    <= {tag_mem[ix], ix};  // victim address
      br_wr_data <= data_mem[ix];
    end
    if (state == S_FILL_REQ) br_addr <= {tag, ix};
    if (state == S_FILL_WAIT && br_rd_data_valid) begin
      data_mem[ix] <= br_rd_data;
      tag_mem[ix]  <= tag;
    end
  end

endmodule

`default_nettype wire

//--- design/uart_rx.sv
/* uart_rx
   8N1 deserializer with mid-bit sampling and a go/dr level handshake */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLK_FREQ  = 20_250_000,
  parameter int BAUD_RATE = 9600
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        go,
  output logic [7:0] data,  // valid while dr is high
  output logic       dr
);
  localparam int BIT_CLKS  = CLK_FREQ / BAUD_RATE;
  localparam int HALF_CLKS = BIT_CLKS / 2;
  localparam int CNT_W     = $clog2(BIT_CLKS + 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic             rx_meta, rx_sync, rx_prev;
  logic [1:0]       state;
  logic [CNT_W-1:0] baud_cnt;
  logic [2:0]       bit_ix;
  logic             bit_end;   // mid-point of the current data or stop bit

  assign bit_end = baud_cnt == CNT_W'(BIT_CLKS - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= S_IDLE;
      baud_cnt <= '0;
      bit_ix   <= '0;
      dr       <= 1'b0;
    end else begin
      rx_meta <= rx;  // two-flop synchronizer
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      if (!go) dr <= 1'b0;  // ack from the mapper
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        S_IDLE: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync) state <= S_START;  // falling edge, start bit
        end
        S_START: begin
          if (baud_cnt == CNT_W'(HALF_CLKS - 1)) begin
            baud_cnt <= '0;
            bit_ix   <= '0;
            state    <= rx_sync ? S_IDLE : S_DATA;  // glitch returns to idle
          end
        end
        S_DATA: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_ix   <= bit_ix + 3'd1;
            if (bit_ix == 3'd7) state <= S_STOP;
          end
        end
        default: begin  // S_STOP
          if (bit_end) begin
            state <= S_IDLE;
            if (rx_sync) dr <= 1'b1;  // framing error drops the byte
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && bit_end) data <= {rx_sync, data[7:1]};  // lsb first
  end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
/* uart_tx
   8N1 serializer, go/bsy level handshake */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLK_FREQ  = 20_250_000,
  parameter int BAUD_RATE = 9600
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire [7:0] data,
  input  wire       go,
  output logic      tx,
  output logic      bsy
);
  localparam int BIT_CLKS = CLK_FREQ / BAUD_RATE;
  localparam int CNT_W    = $clog2(BIT_CLKS + 1);

  logic [9:0]       shift;     // stop, data, start; lsb goes out first
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             go_seen;   // current go already served

  assign tx = shift[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift    <= '1;  // line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
      bsy      <= 1'b0;
      go_seen  <= 1'b0;
    end else begin
      if (!go) go_seen <= 1'b0;  // go dropped, next byte may come
      if (!bsy) begin
        if (go && !go_seen) begin
          shift    <= {1'b1, data, 1'b0};
          baud_cnt <= '0;
          bit_cnt  <= '0;
          bsy      <= 1'b1;
          go_seen  <= 1'b1;
        end
      end else if (baud_cnt == CNT_W'(BIT_CLKS - 1)) begin
        baud_cnt <= '0;
        shift    <= {1'b1, shift[9:1]};  // refill with idle level
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd9) bsy <= 1'b0;  // stop bit done
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/cache_if.sv
/* cache_if
   32-bit access channel from the I/O mapper into the cache */
`timescale 1ns/1ps
`default_nettype none

interface cache_if #(
  parameter int ADDR_W = 32
);
  logic              enable;          // held until the access completes
  logic [ADDR_W-1:0] address;         // byte address, word aligned
  logic [31:0]       data_in;         // already placed in its byte lanes
  logic [3:0]        write_enable;    // one bit per lane, all zero for a read
  logic [31:0]       data_out;
  logic              data_out_ready;  // done when high and busy low
  logic              busy;

  modport requester (
    output enable, address, data_in, write_enable,
    input  data_out, data_out_ready, busy
  );

  modport cache (
    input  enable, address, data_in, write_enable,
    output data_out, data_out_ready, busy
  );
endinterface

`default_nettype wire

//--- design/ramio_pkg.sv
/* ramio shared definitions
   access size codes, the read request word and burst RAM widths */
`default_nettype none

package ramio_pkg;

  // access size, used for writes and as the size field of a read
  typedef enum logic [1:0] {
    SZ_NONE = 2'b00,
    SZ_BYTE = 2'b01,
    SZ_HALF = 2'b10,
    SZ_WORD = 2'b11
  } size_e;

  // read request, raw 0 means no read
  typedef union packed {
    logic [2:0] raw;
    struct packed {
      logic  sign;  // 1: sign extend, 0: zero extend
      size_e size;
    } fields;
  } read_req_u;

  localparam int BR_DATA_W = 64;              // one burst RAM word
  localparam int BR_MASK_W = BR_DATA_W / 8;   // one mask bit per byte

endpackage

`default_nettype wire
